/* verilog/soc_bus_pkg.sv */
// ------------------------------------------------
// CPU bus and address map, 16-bit address, 8-bit data
// A15 picks work RAM, else ROM for reads, video for writes
// ------------------------------------------------
package soc_bus_pkg;

   // Bus widths
   localparam int addr_bits = 16;
   localparam int data_bits = 8;

   // Memory address widths
   localparam int rom_addr_bits   = 12;   // 4 KiB boot ROM
   localparam int ram_addr_bits   = 15;   // 32 KiB work RAM
   localparam int video_addr_bits = 14;   // 16 KiB video memory

   // Address bit selecting the RAM half
   localparam int ram_select_bit = 15;

   // One CPU bus cycle, strobes active high
   typedef struct packed {
      logic [addr_bits-1:0] addr;
      logic [data_bits-1:0] wdata;
      logic                 rd;     // Read strobe
      logic                 wr;     // Write strobe
   } cpu_bus_t;

   // Target of an access
   typedef enum logic [1:0] {
      region_rom,     // Lower half, reads
      region_ram,     // Upper half, reads and writes
      region_video    // Lower half, writes
   } mem_region_e;

endpackage

/* verilog/soc_ctrl_pkg.sv */
// ------------------------------------------------
// Status word from the I/O side and reset hold settings
// ------------------------------------------------
package soc_ctrl_pkg;

   // Hold counter
   localparam int reset_count_bits = 8;
   localparam logic [reset_count_bits-1:0] reset_hold_cycles = 8'd255;

   // Status word, a level from the I/O controller
   typedef struct packed {
      logic [4:0] spare;           // Unused bits 7:3
      logic       menu_reset;      // Bit 2, reset entry in menu
      logic       scanlines_off;   // Bit 1, display option
      logic       power_reset;     // Bit 0, power-up reset
   } status_t;

   // Reset sequencer states
   typedef enum logic [1:0] {
      rst_wait_lock,   // A hold condition is present
      rst_counting,    // Conditions clear, counting the hold
      rst_released     // CPU running
   } reset_state_e;

endpackage

/* verilog/reset_sequencer.sv */
// ------------------------------------------------
// cpu_reset falls reset_hold_cycles edges after all hold
// conditions clear; any condition restarts the count
// ------------------------------------------------
module reset_sequencer import soc_ctrl_pkg::*; (
   input  logic    cpu_clock,
   input  logic    rst,
   input  logic    pll_locked,
   input  status_t status,
   output logic    cpu_reset
);

   reset_state_e                state;
   logic [reset_count_bits-1:0] count;   // Edges since conditions cleared
   logic                        hold;

   // Any reason to keep the CPU stopped
   assign hold = rst || !pll_locked || status.power_reset || status.menu_reset;

   always_ff @(posedge cpu_clock) begin
      if (hold) begin   // Covers rst too
         state     <= rst_wait_lock;
         count     <= '0;
         cpu_reset <= 1'b1;
      end else begin
         case (state)
            rst_wait_lock: begin   // First clear edge
               state <= rst_counting;
               count <= reset_count_bits'(1);
            end
            rst_counting: begin
               if (count == reset_hold_cycles) begin
                  state     <= rst_released;
                  cpu_reset <= 1'b0;
               end else begin
                  count <= count + 1'b1;
               end
            end
            rst_released: ;        // Stay until a condition returns
            default: state <= rst_wait_lock;
         endcase
      end
   end

   // Counter stops at the hold length instead of wrapping
   a_count_bound: assert property (@(posedge cpu_clock) disable iff (rst)
      (count == reset_hold_cycles && !hold) |=> count == reset_hold_cycles);

endmodule

/* verilog/addr_decoder.sv */
// ------------------------------------------------
// One strobe per access; read data muxed by the region
// registered with rd, one cycle latency, no wait states
// ------------------------------------------------
module addr_decoder import soc_bus_pkg::*; (
   input  logic       cpu_clock,
   input  logic       rst,
   input  cpu_bus_t   cpu_bus,
   output logic       rom_rd,
   output logic       ram_rd,
   output logic       ram_wr,
   output logic       video_wr,
   input  logic [7:0] rom_data,
   input  logic [7:0] ram_data,
   output logic [7:0] cpu_din
);

   mem_region_e region;      // Target of the current access
   mem_region_e rd_region;   // Target of the last read
   logic        rd_seen;     // A read has happened since rst

   // A15 set is RAM; lower half splits by direction
   always_comb begin
      if (cpu_bus.addr[ram_select_bit]) region = region_ram;
      else if (cpu_bus.wr)              region = region_video;
      else                              region = region_rom;
   end

   assign rom_rd   = cpu_bus.rd && (region == region_rom);
   assign ram_rd   = cpu_bus.rd && (region == region_ram);
   assign ram_wr   = cpu_bus.wr && (region == region_ram);
   assign video_wr = cpu_bus.wr && (region == region_video);

   // Remember the source of each read for the next cycle
   always_ff @(posedge cpu_clock) begin
      if (rst) begin
         rd_region <= region_rom;
         rd_seen   <= 1'b0;
      end else if (cpu_bus.rd) begin
         rd_region <= region;
         rd_seen   <= 1'b1;
      end
   end

   // Memory outputs only change on rd, so data holds between reads
   always_comb begin
      if (!rd_seen)                       cpu_din = 8'h00;
      else if (rd_region == region_ram)   cpu_din = ram_data;
      else                                cpu_din = rom_data;   // Video is write-only
   end

   // CPU never reads and writes in one cycle
   a_no_rd_wr: assert property (@(posedge cpu_clock) disable iff (rst)
      !(cpu_bus.rd && cpu_bus.wr));

endmodule

/* verilog/boot_rom.sv */
// ------------------------------------------------
// 4 KiB ROM, image from boot_rom.hex in the run directory
// ------------------------------------------------
module boot_rom import soc_bus_pkg::*; (
   input  logic                     cpu_clock,
   input  logic                     rd,
   input  logic [rom_addr_bits-1:0] addr,
   output logic [7:0]               q
);

   localparam int depth = 1 << rom_addr_bits;

   logic [7:0] rom [depth];

   // Program image, loaded at elaboration
   initial begin
      $readmemh("boot_rom.hex", rom);
   end

   // Output only moves on a read
   always_ff @(posedge cpu_clock) begin
      if (rd) begin
         q <= rom[addr];
      end
   end

endmodule

/* verilog/work_ram.sv */
// ------------------------------------------------
// 32 KiB RAM in place of SDRAM, one-cycle read
// Contents undefined after power-up
// ------------------------------------------------
module work_ram import soc_bus_pkg::*; (
   input  logic                     cpu_clock,
   input  logic                     rd,
   input  logic                     wr,
   input  logic [ram_addr_bits-1:0] addr,
   input  logic [7:0]               wdata,
   output logic [7:0]               q
);

   localparam int depth = 1 << ram_addr_bits;

   logic [7:0] mem [depth];

   always_ff @(posedge cpu_clock) begin
      if (wr) begin
         mem[addr] <= wdata;   // Visible to a read on the next edge
      end
   end

   // Read data registered, holds when rd is low
   always_ff @(posedge cpu_clock) begin
      if (rd) begin
         q <= mem[addr];
      end
   end

endmodule

/* verilog/video_ram.sv */
// ------------------------------------------------
// 16 KiB video buffer, CPU write only, display reads
// on a second port with one cycle latency
// ------------------------------------------------
module video_ram import soc_bus_pkg::*; (
   input  logic                       cpu_clock,
   input  logic                       wr,
   input  logic [video_addr_bits-1:0] addr,
   input  logic [7:0]                 wdata,
   input  logic [video_addr_bits-1:0] vid_addr,
   output logic [7:0]                 vid_data
);

   localparam int depth = 1 << video_addr_bits;

   logic [7:0] mem [depth];   // Character or pixel data

   // CPU port
   always_ff @(posedge cpu_clock) begin
      if (wr) begin
         mem[addr] <= wdata;
      end
   end

   // Display fetch port, reads every cycle
   always_ff @(posedge cpu_clock) begin
      vid_data <= mem[vid_addr];
   end

   // Decoder must hand over a clean address with the strobe
   a_wr_addr_known: assert property (@(posedge cpu_clock)
      wr |-> !$isunknown(addr));

endmodule

/* verilog/soc_core.sv */
// ------------------------------------------------
// Fabric top, CPU bus driven from outside
// Status bit 1 not used here
// ------------------------------------------------
module soc_core
   import soc_bus_pkg::*;
   import soc_ctrl_pkg::*;
(
   input  logic                       cpu_clock,
   input  logic                       rst,
   input  logic                       pll_locked,
   input  status_t                    status,
   input  cpu_bus_t                   cpu_bus,
   output logic [7:0]                 cpu_din,
   output logic                       cpu_reset,
   input  logic [video_addr_bits-1:0] vid_addr,
   output logic [7:0]                 vid_data
);

   logic       rom_rd;
   logic       ram_rd;
   logic       ram_wr;
   logic       video_wr;
   logic [7:0] rom_data;
   logic [7:0] ram_data;

   reset_sequencer u_reset_sequencer (
      .cpu_clock  (cpu_clock),
      .rst        (rst),
      .pll_locked (pll_locked),
      .status     (status),
      .cpu_reset  (cpu_reset)
   );

   addr_decoder u_addr_decoder (
      .cpu_clock (cpu_clock),
      .rst       (rst),
      .cpu_bus   (cpu_bus),
      .rom_rd    (rom_rd),
      .ram_rd    (ram_rd),
      .ram_wr    (ram_wr),
      .video_wr  (video_wr),
      .rom_data  (rom_data),
      .ram_data  (ram_data),
      .cpu_din   (cpu_din)
   );

   boot_rom u_boot_rom (
      .cpu_clock (cpu_clock),
      .rd        (rom_rd),
      .addr      (cpu_bus.addr[rom_addr_bits-1:0]),   // Image repeats within lower half
      .q         (rom_data)
   );

   work_ram u_work_ram (
      .cpu_clock (cpu_clock),
      .rd        (ram_rd),
      .wr        (ram_wr),
      .addr      (cpu_bus.addr[ram_addr_bits-1:0]),
      .wdata     (cpu_bus.wdata),
      .q         (ram_data)
   );

   video_ram u_video_ram (
      .cpu_clock (cpu_clock),
      .wr        (video_wr),
      .addr      (cpu_bus.addr[video_addr_bits-1:0]),
      .wdata     (cpu_bus.wdata),
      .vid_addr  (vid_addr),
      .vid_data  (vid_data)
   );

endmodule

/* test/clock_gen.sv */
// ------------------------------------------------
// 100 ns cpu_clock, rst high for the first 2 edges
// ------------------------------------------------
module clock_gen (
   output logic cpu_clock,
   output logic rst
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      cpu_clock = 1'b0;
      forever #50 cpu_clock = ~cpu_clock;   // Half period
   end

   initial begin
      rst <= 1'b1;
      repeat (2) @(posedge cpu_clock);
      rst <= 1'b0;   // First seen low on edge 3
   end

endmodule

/* test/tb_soc_core.sv */
// ------------------------------------------------
// Table-driven test of soc_core with boot_rom.hex in the run directory
// RAM and video bytes checked only where written first
// ------------------------------------------------
module tb_soc_core import soc_bus_pkg::*, soc_ctrl_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum {op_read, op_write, op_video, op_status} op_e;

   typedef struct {
      string       name;
      op_e         op;
      logic [15:0] addr;
      logic [7:0]  data;       // Write byte or status word
      logic [7:0]  expected;   // Read byte, hold edges for status
   } test_entry_t;

   localparam int watch_cycles_per_test = 300;
   localparam int release_limit = int'(reset_hold_cycles) + 16;   // Cap on the hold count

   logic                       cpu_clock;
   logic                       rst;
   logic                       pll_locked;
   status_t                    status;
   cpu_bus_t                   cpu_bus;
   logic [7:0]                 cpu_din;
   logic                       cpu_reset;
   logic [video_addr_bits-1:0] vid_addr;
   logic [7:0]                 vid_data;

   // Reference memories
   logic [7:0] rom_model   [1 << rom_addr_bits];
   logic [7:0] ram_model   [1 << ram_addr_bits];
   logic [7:0] video_model [1 << video_addr_bits];

   test_entry_t tests[$];
   int          seed = 32'h19ac_6e04;
   int          pending = -1;   // Row whose data is due at this negedge
   int          tests_run = 0;
   int          failures = 0;
   bit          table_ready = 1'b0;

   clock_gen u_clock_gen (
      .cpu_clock (cpu_clock),
      .rst       (rst)
   );

   soc_core dut (
      .cpu_clock  (cpu_clock),
      .rst        (rst),
      .pll_locked (pll_locked),
      .status     (status),
      .cpu_bus    (cpu_bus),
      .cpu_din    (cpu_din),
      .cpu_reset  (cpu_reset),
      .vid_addr   (vid_addr),
      .vid_data   (vid_data)
   );

   function automatic logic [7:0] rand_byte();
      return 8'($random(seed));
   endfunction

   // Appends a row with its expected value from the address map
   function automatic void add_test(input string name, input op_e op,
                                    input logic [15:0] addr, input logic [7:0] data);
      test_entry_t row;
      row = '{name, op, addr, data, 8'h00};
      case (op)
         op_write: begin
            if (addr[ram_select_bit]) ram_model[addr[ram_addr_bits-1:0]] = data;
            else                      video_model[addr[video_addr_bits-1:0]] = data;
         end
         op_read: begin
            if (addr[ram_select_bit]) row.expected = ram_model[addr[ram_addr_bits-1:0]];
            else                      row.expected = rom_model[addr[rom_addr_bits-1:0]];
         end
         op_video:  row.expected = video_model[addr[video_addr_bits-1:0]];
         op_status: row.expected = reset_hold_cycles;
      endcase
      tests.push_back(row);
   endfunction

   function automatic void build_table();
      add_test("ram_wr_8000", op_write, 16'h8000, rand_byte());
      add_test("ram_wr_8001", op_write, 16'h8001, rand_byte());
      add_test("ram_wr_ffff", op_write, 16'hFFFF, rand_byte());
      add_test("ram_wr_c123", op_write, 16'hC123, 8'h5C);
      add_test("ram_rd_8000", op_read, 16'h8000, 8'h00);   // Back-to-back reads
      add_test("ram_rd_8001", op_read, 16'h8001, 8'h00);
      add_test("ram_rd_ffff", op_read, 16'hFFFF, 8'h00);
      add_test("ram_rd_c123", op_read, 16'hC123, 8'h00);
      add_test("ram_wr_9000", op_write, 16'h9000, rand_byte());
      add_test("ram_rd_9000_next", op_read, 16'h9000, 8'h00);   // Read right after write
      add_test("rom_rd_0405", op_read, 16'h0405, 8'h00);
      add_test("rom_rd_0ff7", op_read, 16'h0FF7, 8'h00);
      add_test("rom_rd_0102", op_read, 16'h0102, 8'h00);   // Zero block
      add_test("vid_wr_0003", op_write, 16'h0003, 8'h5A);
      add_test("vid_wr_2030", op_write, 16'h2030, 8'hA5);
      add_test("vid_wr_7c02", op_write, 16'h7C02, rand_byte());
      add_test("rom_rd_0003_after_wr", op_read, 16'h0003, 8'h00);
      add_test("rom_rd_2030_after_wr", op_read, 16'h2030, 8'h00);   // ROM mirror
      add_test("rom_rd_7c02_after_wr", op_read, 16'h7C02, 8'h00);
      add_test("vid_rd_0003", op_video, 16'h0003, 8'h00);
      add_test("vid_rd_2030", op_video, 16'h2030, 8'h00);
      add_test("vid_rd_3c02", op_video, 16'h3C02, 8'h00);
      add_test("menu_reset", op_status, 16'h0000, 8'h04);
      add_test("power_reset", op_status, 16'h0000, 8'h01);
      add_test("ram_rd_c123_after_reset", op_read, 16'hC123, 8'h00);
   endfunction

   function automatic void check_value(input string name, input logic [31:0] expected,
                                       input logic [31:0] actual);
      tests_run++;
      assert (actual === expected) begin
         $display("[PASS] %s", name);
      end else begin
         failures++;
         $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      end
   endfunction

   function automatic void compare_read(input int idx);
      logic [7:0] actual;
      actual = (tests[idx].op == op_video) ? vid_data : cpu_din;
      check_value(tests[idx].name, 32'(tests[idx].expected), 32'(actual));
   endfunction

   // Drives one bus cycle or an idle one for a negative idx
   task automatic drive_bus_cycle(input int idx);
      cpu_bus_t    next_bus;
      test_entry_t row;
      next_bus = '0;
      if (idx >= 0) begin
         row            = tests[idx];
         next_bus.addr  = row.addr;
         next_bus.wdata = row.data;
         next_bus.rd    = (row.op == op_read);
         next_bus.wr    = (row.op == op_write);
      end
      @(posedge cpu_clock);
      cpu_bus <= next_bus;
      if (idx >= 0 && row.op == op_video) vid_addr <= row.addr[video_addr_bits-1:0];
      @(negedge cpu_clock);
      if (pending >= 0) compare_read(pending);   // Sampled on the last edge and stable now
      pending = -1;
      if (idx >= 0) begin
         if (row.op == op_write) begin
            tests_run++;
            $display("[DONE] %s", row.name);
         end else begin
            pending = idx;
         end
      end
   endtask

   // Edges from the first clear edge until cpu_reset is seen low
   task automatic measure_release(output int edges);
      edges = 0;
      @(posedge cpu_clock);   // Clear first sampled here
      @(negedge cpu_clock);
      while (cpu_reset !== 1'b0 && edges < release_limit) begin
         @(posedge cpu_clock);
         @(negedge cpu_clock);
         edges++;
      end
   endtask

   task automatic pulse_status(input int idx);
      int edges;
      @(posedge cpu_clock);
      status <= status_t'(tests[idx].data);
      @(posedge cpu_clock);                  // Status bit sampled
      @(negedge cpu_clock);
      check_value({tests[idx].name, "_rise"}, 32'd1, 32'(cpu_reset));
      repeat (3) @(posedge cpu_clock);
      status <= '0;
      measure_release(edges);
      check_value({tests[idx].name, "_release"}, 32'(tests[idx].expected), 32'(edges));
   endtask

   initial begin
      int edges;
      cpu_bus    <= '0;
      status     <= '0;
      pll_locked <= 1'b1;
      vid_addr   <= '0;
      $readmemh("boot_rom.hex", rom_model);
      build_table();
      table_ready = 1'b1;

      @(negedge rst);   // Power-up hold
      measure_release(edges);
      check_value("reset_release", 32'(reset_hold_cycles), 32'(edges));
      check_value("cpu_din_after_reset", 32'h0, 32'(cpu_din));   // No read yet

      for (int i = 0; i < tests.size(); i++) begin
         if (tests[i].op == op_status) begin
            drive_bus_cycle(-1);   // Retire the read in flight
            pulse_status(i);
         end else begin
            drive_bus_cycle(i);
         end
      end
      drive_bus_cycle(-1);

      $display("Tests run: %0d  failures: %0d", tests_run, failures);
      if (failures == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      wait (table_ready);
      repeat (tests.size() * watch_cycles_per_test + int'(reset_hold_cycles)) begin
         @(posedge cpu_clock);
      end
      $display("Timeout, the test table did not finish in time");
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* boot_rom.hex */
// Boot ROM image for $readmemh, hex bytes, 16 per line
// @ lines give the byte address of the next line; each block counts from its own base
@000
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F
30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
@100
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
@400
40 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F
@800
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
@C00
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF
@FF0
F0 F1 F2 F3 F4 F5 F6 F7 F8 F9 FA FB FC FD FE FF

/* vlog.f */
verilog/soc_bus_pkg.sv
verilog/soc_ctrl_pkg.sv
verilog/reset_sequencer.sv
verilog/addr_decoder.sv
verilog/boot_rom.sv
verilog/work_ram.sv
verilog/video_ram.sv
verilog/soc_core.sv
test/clock_gen.sv
test/tb_soc_core.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run from the project root, grep the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_soc_core -Mdir obj_dir -f vlog.f \
   || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/Vtb_soc_core 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED" \
   && echo "Simulation run ok" \
   || { echo "Simulation run failed"; exit 1; }
